/* tb.f */
+incdir+include
logic/serdes_pkg.sv
logic/serdes_cfg_regs.sv
logic/serdes_link_ctrl.sv
logic/serdes_tx_serializer.sv
logic/serdes_rx_deserializer.sv
logic/io_serdes.sv
tests/serdes_clock_gen.sv
tests/io_serdes_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= io_serdes_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

SIM      := $(BUILD_DIR)/V$(TOP)
SOURCES  := $(filter %.sv %.v,$(shell cat $(FILELIST))) $(wildcard include/*.svh)
PASS_MSG := Done: no errors

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tests/io_serdes_tb.sv */
`timescale 1ns/1ps
`include "serdes_consts.svh"

module io_serdes_tb;

	localparam int CLK_PERIOD = 40;
	localparam int LOOP_BEATS = 20;
	localparam int BEAT_GAP   = 8;    // cycles from one strobe to the next
	localparam int RX_WINDOW  = 16;
	localparam int WD_CYCLES  = 40 * (LOOP_BEATS + 2) + 300;
	localparam logic [31:0] SEED = 32'h5d48_dfd7;
	localparam logic [`SERDES_CFG_ADDR_W-1:0] CTRL_ADDR = 15'h0000;  // dword 0

	logic                       ioclk;
	logic                       axis_rst_n;
	logic                       cc_is_enable;
	serdes_pkg::cfg_write_t     cfg_wr;
	logic                       awready;
	logic                       wready;
	logic                       arready;
	logic                       rvalid;
	logic [`SERDES_DATA_W-1:0]  rdata;
	serdes_pkg::axis_beat_t     as_is;
	logic                       as_is_tready;
	serdes_pkg::serial_lanes_t  serial_txd;
	serdes_pkg::serial_lanes_t  serial_rxd;
	serdes_pkg::axis_beat_t     is_as;
	logic                       is_as_tready;

	logic [31:0]            rng_state;
	int                     cycle;
	int                     n_checks;
	int                     n_errors;
	string                  cur_test;
	serdes_pkg::axis_beat_t rx_q[$];  // every beat seen on is_as
	int                     rx_t[$];

	serdes_clock_gen #(.PERIOD_NS(CLK_PERIOD), .RST_CYCLES(3)) clk_gen_i (
		.ioclk      (ioclk),
		.axis_rst_n (axis_rst_n)
	);

	io_serdes io_serdes_i (
		.ioclk        (ioclk),
		.axis_rst_n   (axis_rst_n),
		.cc_is_enable (cc_is_enable),
		.cfg_wr       (cfg_wr),
		.awready      (awready),
		.wready       (wready),
		.arready      (arready),
		.rvalid       (rvalid),
		.rdata        (rdata),
		.as_is        (as_is),
		.as_is_tready (as_is_tready),
		.serial_txd   (serial_txd),
		.serial_rxd   (serial_rxd),
		.is_as        (is_as),
		.is_as_tready (is_as_tready)
	);

	assign serial_rxd = serial_txd;  // straight loopback

	always @(posedge ioclk or negedge axis_rst_n) begin
		if (!axis_rst_n) begin
			cycle <= 0;
		end else begin
			cycle <= cycle + 1;
		end
	end

	////////////////////
	// receive monitor
	always @(negedge ioclk) begin
		if (axis_rst_n === 1'b1 && is_as.tvalid === 1'b1) begin
			rx_q.push_back(is_as);
			rx_t.push_back(cycle);
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic serdes_pkg::axis_beat_t random_beat();
		serdes_pkg::axis_beat_t b;
		logic [31:0]            r;
		b = '0;
		rng_state = xorshift(rng_state);
		b.tdata = rng_state;
		rng_state = xorshift(rng_state);
		r = rng_state;
		b.tstrb  = r[3:0];
		b.tkeep  = r[7:4];
		b.tid    = r[9:8];
		b.tuser  = r[11:10];
		b.tlast  = r[12];
		b.tvalid = 1'b1;
		return b;
	endfunction

	function automatic serdes_pkg::cfg_ctrl_t ctrl_val(input logic tx, input logic rx);
		serdes_pkg::cfg_ctrl_t c;
		c.txen_ctl = tx;
		c.rxen_ctl = rx;
		return c;
	endfunction

	////////////////////
	// compare tasks
	task automatic check_beat(input string what, input serdes_pkg::axis_beat_t exp,
			input serdes_pkg::axis_beat_t act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("Error in %s, %s: expected %h, actual %h", cur_test, what, exp, act);
		end
	endtask

	task automatic check_ctrl(input string what, input serdes_pkg::cfg_ctrl_t exp,
			input serdes_pkg::cfg_ctrl_t act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("Error in %s, %s: expected %b, actual %b", cur_test, what, exp, act);
		end
	endtask

	task automatic check_bit(input string what, input logic exp, input logic act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("Error in %s, %s: expected %b, actual %b", cur_test, what, exp, act);
		end
	endtask

	task automatic check_rdata(input string what, input serdes_pkg::cfg_ctrl_t exp);
		check_ctrl(what, exp, serdes_pkg::cfg_ctrl_t'(rdata[1:0]));
		check_bit({what, ", upper rdata"}, 1'b0, |rdata[`SERDES_DATA_W-1:2]);
	endtask

	////////////////////
	// bus and stream drivers
	task automatic cfg_write(input logic [`SERDES_CFG_ADDR_W-1:0] addr,
			input logic [`SERDES_DATA_W-1:0] data, input logic [3:0] strb,
			input logic en, input logic aw, input logic w);
		@(negedge ioclk);
		cc_is_enable   = en;
		cfg_wr.awvalid = aw;
		cfg_wr.awaddr  = addr;
		cfg_wr.wvalid  = w;
		cfg_wr.wdata   = data;
		cfg_wr.wstrb   = strb;
		#1;
		check_bit("awready", aw & w & en, awready);
		check_bit("wready", aw & w & en, wready);
		@(negedge ioclk);
		cfg_wr       = '0;
		cc_is_enable = 1'b1;
	endtask

	task automatic strobe_beat(input serdes_pkg::axis_beat_t b, output int at);
		@(negedge ioclk);
		as_is = b;
		at    = cycle;
		@(negedge ioclk);
		as_is.tvalid = 1'b0;  // one-cycle strobe
	endtask

	task automatic wait_ready(input logic level, input int limit);
		bit ok;
		ok = 1'b0;
		n_checks++;
		for (int i = 0; i < limit && !ok; i++) begin
			@(negedge ioclk);
			if (is_as_tready === level) begin
				ok = 1'b1;
			end
		end
		if (!ok) begin
			n_errors++;
			$display("%s: is_as_tready did not go to %b within %0d cycles", cur_test, level, limit);
		end
	endtask

	task automatic wait_beat(input int count, input int limit);
		n_checks++;
		for (int i = 0; i < limit && rx_q.size() < count; i++) begin
			@(negedge ioclk);
		end
		if (rx_q.size() < count) begin
			n_errors++;
			$display("%s: no beat came back on is_as within %0d cycles", cur_test, limit);
		end
	endtask

	////////////////////
	// directed tests
	task automatic test_reset();
		cur_test = "test_reset";
		as_is_tready = 1'b1;  // idle frames now carry a ready bit that only blanking hides
		repeat (8) begin
			@(negedge ioclk);
			check_bit("serial_txd blank", 1'b1, serial_txd == '0);
			check_bit("is_as tvalid", 1'b0, is_as.tvalid);
			check_bit("is_as_tready", 1'b0, is_as_tready);
			check_bit("arready", 1'b1, arready);
			check_bit("rvalid", 1'b1, rvalid);
			check_rdata("ctrl", ctrl_val(1'b0, 1'b0));
		end
	endtask

	task automatic test_cfg();
		cur_test = "test_cfg";
		cfg_write(CTRL_ADDR, 32'h1, 4'h1, 1'b1, 1'b1, 1'b1);
		check_rdata("rxen written", ctrl_val(1'b0, 1'b1));
		cfg_write(CTRL_ADDR, 32'h0, 4'h1, 1'b1, 1'b1, 1'b1);
		check_rdata("cleared", ctrl_val(1'b0, 1'b0));
		cfg_write(CTRL_ADDR, 32'h1, 4'h1, 1'b1, 1'b1, 1'b1);
		check_rdata("rxen again", ctrl_val(1'b0, 1'b1));
		cfg_write(CTRL_ADDR, 32'h0, 4'he, 1'b1, 1'b1, 1'b1);  // byte 0 masked
		check_rdata("wstrb0 clear", ctrl_val(1'b0, 1'b1));
		cfg_write(15'h0004, 32'h0, 4'hf, 1'b1, 1'b1, 1'b1);
		check_rdata("other offset", ctrl_val(1'b0, 1'b1));
		cfg_write(CTRL_ADDR, 32'h0, 4'hf, 1'b0, 1'b1, 1'b1);
		check_rdata("port disabled", ctrl_val(1'b0, 1'b1));
		cfg_write(CTRL_ADDR, 32'h0, 4'hf, 1'b1, 1'b1, 1'b0);
		check_rdata("awvalid only", ctrl_val(1'b0, 1'b1));
		cfg_write(CTRL_ADDR, 32'h0, 4'hf, 1'b1, 1'b0, 1'b1);
		check_rdata("wvalid only", ctrl_val(1'b0, 1'b1));
	endtask

	task automatic test_startup();
		int rdy_at;
		int lanes_at;
		cur_test = "test_startup";
		rdy_at   = -1;
		lanes_at = -1;
		@(negedge ioclk);
		as_is_tready = 1'b1;
		cfg_write(CTRL_ADDR, 32'h3, 4'h1, 1'b1, 1'b1, 1'b1);
		for (int i = 0; i < 12; i++) begin
			@(negedge ioclk);
			if (lanes_at < 0 && serial_txd != '0) begin
				lanes_at = i;
			end
			if (rdy_at < 0 && is_as_tready === 1'b1) begin
				rdy_at = i;
			end
		end
		check_rdata("both enabled", ctrl_val(1'b1, 1'b1));
		n_checks++;
		if (rdy_at < 0 || rdy_at >= 8) begin
			n_errors++;
			$display("%s: is_as_tready did not come up within 8 cycles", cur_test);
		end else if (lanes_at >= 0 && lanes_at < rdy_at - 1) begin
			n_errors++;
			$display("%s: lanes were driven before transmit came on", cur_test);
		end
	endtask

	task automatic test_loopback();
		serdes_pkg::axis_beat_t exp_q[$];
		int                     sent_q[$];
		serdes_pkg::axis_beat_t b;
		int                     at;
		int                     base;
		int                     got;
		cur_test = "test_loopback";
		base = rx_q.size();
		for (int i = 0; i < LOOP_BEATS; i++) begin
			b = random_beat();
			strobe_beat(b, at);
			b.tready = 1'b1;  // far side ready travels back with the beat
			exp_q.push_back(b);
			sent_q.push_back(at);
			repeat (BEAT_GAP - 2) @(negedge ioclk);
		end
		repeat (RX_WINDOW) @(negedge ioclk);
		got = rx_q.size() - base;
		n_checks++;
		if (got != LOOP_BEATS) begin
			n_errors++;
			$display("Error in %s, returned beats: expected %0d, actual %0d",
				cur_test, LOOP_BEATS, got);
		end
		for (int i = 0; i < LOOP_BEATS && i < got; i++) begin
			n_checks++;
			if (rx_t[base + i] - sent_q[i] > RX_WINDOW) begin
				n_errors++;
				$display("%s: beat %0d came back later than %0d cycles", cur_test, i, RX_WINDOW);
			end
			check_beat($sformatf("beat %0d", i), exp_q[i], rx_q[base + i]);
		end
	endtask

	task automatic test_flow_ctrl();
		serdes_pkg::axis_beat_t b;
		int                     at;
		int                     base;
		cur_test = "test_flow_ctrl";
		@(negedge ioclk);
		as_is_tready = 1'b0;
		wait_ready(1'b0, RX_WINDOW);
		base = rx_q.size();
		b = random_beat();
		strobe_beat(b, at);
		repeat (RX_WINDOW) @(negedge ioclk);
		n_checks++;
		if (rx_q.size() != base) begin
			n_errors++;
			$display("%s: a beat came back while the far side was not ready", cur_test);
		end
		as_is_tready = 1'b1;
		wait_ready(1'b1, RX_WINDOW);
		base = rx_q.size();
		b = random_beat();
		strobe_beat(b, at);
		wait_beat(base + 1, RX_WINDOW);
		if (rx_q.size() > base) begin
			b.tready = 1'b1;
			check_beat("beat after ready", b, rx_q[base]);
		end
	endtask

	////////////////////
	// main sequence
	initial begin
		cc_is_enable = 1'b0;
		cfg_wr       = '0;
		as_is        = '0;
		as_is_tready = 1'b0;
		rng_state    = SEED;
		n_checks     = 0;
		n_errors     = 0;
		cur_test     = "init";
		@(posedge axis_rst_n);
		test_reset();
		test_cfg();
		test_startup();
		test_loopback();
		test_flow_ctrl();
		if (n_errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$display("%0d checks, %0d errors", n_checks, n_errors);
		$finish;
	end

	// watchdog
	initial begin
		#(WD_CYCLES * CLK_PERIOD);
		$display("timeout: tests still running after %0d cycles in %s", WD_CYCLES, cur_test);
		$display("Done: errors found");
		$display("%0d checks, %0d errors", n_checks, n_errors);
		$finish;
	end

endmodule

/* tests/serdes_clock_gen.sv */
`timescale 1ns/1ps

module serdes_clock_gen #(
	parameter int PERIOD_NS  = 40,
	parameter int RST_CYCLES = 3
) (
	output logic ioclk,
	output logic axis_rst_n
);

	initial begin
		ioclk = 1'b0;
		forever #(PERIOD_NS / 2) ioclk = ~ioclk;
	end

	// release on a falling edge, away from the sampling edge
	initial begin
		axis_rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge ioclk);
		@(negedge ioclk);
		axis_rst_n = 1'b1;
	end

endmodule

/* logic/io_serdes.sv */
`timescale 1ns/1ps
`include "serdes_consts.svh"

module io_serdes (
	input  logic                       ioclk,
	input  logic                       axis_rst_n,
	input  logic                       cc_is_enable,
	input  serdes_pkg::cfg_write_t     cfg_wr,
	output logic                       awready,
	output logic                       wready,
	output logic                       arready,
	output logic                       rvalid,
	output logic [`SERDES_DATA_W-1:0]  rdata,
	input  serdes_pkg::axis_beat_t     as_is,
	input  logic                       as_is_tready,
	output serdes_pkg::serial_lanes_t  serial_txd,
	input  serdes_pkg::serial_lanes_t  serial_rxd,
	output serdes_pkg::axis_beat_t     is_as,
	output logic                       is_as_tready
);

	serdes_pkg::cfg_ctrl_t                ctrl;
	logic [$clog2(`SERDES_CLK_RATIO)-1:0] phase;
	logic                                 txen;
	logic                                 rxen;
	logic                                 frame_valid;
	logic                                 remote_tready;

	////////////////////
	// control
	serdes_cfg_regs cfg_regs_i (
		.ioclk        (ioclk),
		.axis_rst_n   (axis_rst_n),
		.cc_is_enable (cc_is_enable),
		.cfg_wr       (cfg_wr),
		.awready      (awready),
		.wready       (wready),
		.arready      (arready),
		.rvalid       (rvalid),
		.rdata        (rdata),
		.ctrl         (ctrl)
	);

	serdes_link_ctrl link_ctrl_i (
		.ioclk         (ioclk),
		.axis_rst_n    (axis_rst_n),
		.ctrl          (ctrl),
		.frame_valid   (frame_valid),
		.remote_tready (remote_tready),
		.phase         (phase),
		.txen          (txen),
		.rxen          (rxen),
		.is_as_tready  (is_as_tready)
	);

	////////////////////
	// data paths
	serdes_tx_serializer tx_i (
		.ioclk        (ioclk),
		.axis_rst_n   (axis_rst_n),
		.as_is        (as_is),
		.as_is_tready (as_is_tready),
		.phase        (phase),
		.txen         (txen),
		.is_as_tready (is_as_tready),
		.serial_txd   (serial_txd)
	);

	serdes_rx_deserializer rx_i (
		.ioclk         (ioclk),
		.axis_rst_n    (axis_rst_n),
		.serial_rxd    (serial_rxd),
		.phase         (phase),
		.rxen          (rxen),
		.is_as         (is_as),
		.frame_valid   (frame_valid),
		.remote_tready (remote_tready)
	);

endmodule

/* logic/serdes_rx_deserializer.sv */
`timescale 1ns/1ps
`include "serdes_consts.svh"

module serdes_rx_deserializer (
	input  logic                                ioclk,
	input  logic                                axis_rst_n,
	input  serdes_pkg::serial_lanes_t           serial_rxd,
	input  logic [$clog2(`SERDES_CLK_RATIO)-1:0] phase,
	input  logic                                rxen,
	output serdes_pkg::axis_beat_t              is_as,
	output logic                                frame_valid,
	output logic                                remote_tready
);

	localparam int PH_W = $clog2(`SERDES_CLK_RATIO);
	localparam logic [PH_W-1:0] LAST_PH = PH_W'(`SERDES_LAST_PHASE);

	// one lane vector per phase, index k holds what came in at phase k
	serdes_pkg::serial_lanes_t [`SERDES_CLK_RATIO-1:0] rx_hist_q;
	serdes_pkg::serial_lanes_t [`SERDES_CLK_RATIO-1:0] rx_hist_d;
	logic [`SERDES_CLK_RATIO-1:0] id_nib;
	logic [`SERDES_CLK_RATIO-1:0] fc_nib;
	serdes_pkg::axis_beat_t rx_beat;
	serdes_pkg::axis_beat_t beat_q;
	logic                   data_vld_q;
	logic                   remote_rdy_q;
	logic                   frame_end;

	assign frame_end = rxen && (phase == LAST_PH);

	////////////////////
	// sample the lanes
	assign rx_hist_d = {serial_rxd, rx_hist_q[`SERDES_CLK_RATIO-1:1]};

	always_ff @(posedge ioclk or negedge axis_rst_n) begin
		if (!axis_rst_n) begin
			rx_hist_q <= '0;
		end else if (rxen) begin
			rx_hist_q <= rx_hist_d;
		end
	end

	// regroup the phases into nibbles, last bit still on the wire
	always_comb begin
		rx_beat = '0;
		for (int k = 0; k < `SERDES_CLK_RATIO; k++) begin
			for (int j = 0; j < `SERDES_DATA_LANES; j++) begin
				rx_beat.tdata[j*`SERDES_CLK_RATIO + k] = rx_hist_d[k].tdata[j];
			end
			rx_beat.tstrb[k] = rx_hist_d[k].tstrb;
			rx_beat.tkeep[k] = rx_hist_d[k].tkeep;
			id_nib[k]        = rx_hist_d[k].tid_tuser;
			fc_nib[k]        = rx_hist_d[k].fc;
		end
		{rx_beat.tid, rx_beat.tuser} = id_nib;
		rx_beat.tlast  = fc_nib[2];
		rx_beat.tvalid = fc_nib[1];
		rx_beat.tready = fc_nib[0];  // fc_nib[3] is a spare
	end

	////////////////////
	// output beat
	always_ff @(posedge ioclk) begin
		if (frame_end) begin
			beat_q <= rx_beat;
		end
	end

	always_ff @(posedge ioclk or negedge axis_rst_n) begin
		if (!axis_rst_n) begin
			data_vld_q   <= 1'b0;
			remote_rdy_q <= 1'b0;
		end else begin
			data_vld_q <= frame_end && rx_beat.tvalid;  // empty frames give no strobe
			if (frame_end) begin
				remote_rdy_q <= rx_beat.tready;  // every frame refreshes it
			end
		end
	end

	always_comb begin
		is_as        = beat_q;
		is_as.tvalid = data_vld_q;
		is_as.tready = remote_rdy_q;
	end

	assign frame_valid   = data_vld_q;
	assign remote_tready = remote_rdy_q;

	// at most one beat per frame
	a_tvalid_strobe : assert property (
		@(posedge ioclk) disable iff (!axis_rst_n)
		is_as.tvalid |=> !is_as.tvalid
	);

endmodule

/* logic/serdes_tx_serializer.sv */
`timescale 1ns/1ps
`include "serdes_consts.svh"

module serdes_tx_serializer (
	input  logic                                ioclk,
	input  logic                                axis_rst_n,
	input  serdes_pkg::axis_beat_t              as_is,
	input  logic                                as_is_tready,
	input  logic [$clog2(`SERDES_CLK_RATIO)-1:0] phase,
	input  logic                                txen,
	input  logic                                is_as_tready,
	output serdes_pkg::serial_lanes_t           serial_txd
);

	localparam int PH_W = $clog2(`SERDES_CLK_RATIO);
	localparam logic [PH_W-1:0] LAST_PH = PH_W'(`SERDES_LAST_PHASE);

	serdes_pkg::axis_beat_t    pend_beat;
	logic                      pend_vld;
	serdes_pkg::axis_beat_t    send_beat;
	serdes_pkg::axis_beat_t    tx_buf;
	logic [`SERDES_CLK_RATIO-1:0] id_nib;
	logic [`SERDES_CLK_RATIO-1:0] fc_nib;
	serdes_pkg::serial_lanes_t lanes;
	logic                      frame_end;

	assign frame_end = (phase == LAST_PH);

	////////////////////
	// pending beat, a later strobe in the same frame overwrites it
	always_ff @(posedge ioclk) begin
		if (as_is.tvalid) begin
			pend_beat <= as_is;
		end
	end

	always_ff @(posedge ioclk or negedge axis_rst_n) begin
		if (!axis_rst_n) begin
			pend_vld <= 1'b0;
		end else if (frame_end) begin
			pend_vld <= as_is.tvalid;  // strobe on the boundary goes out next frame
		end else if (as_is.tvalid) begin
			pend_vld <= 1'b1;
		end
	end

	// idle frames carry only the ready bit
	always_comb begin
		send_beat        = pend_vld ? pend_beat : '0;
		send_beat.tvalid = pend_vld & is_as_tready;  // far side not ready, beat is dropped
		send_beat.tready = as_is_tready;
	end

	always_ff @(posedge ioclk) begin
		if (frame_end) begin
			tx_buf <= send_beat;
		end
	end

	////////////////////
	// one nibble bit per lane per phase
	assign id_nib = {tx_buf.tid, tx_buf.tuser};
	assign fc_nib = {1'b0, tx_buf.tlast, tx_buf.tvalid, tx_buf.tready};

	always_comb begin
		for (int j = 0; j < `SERDES_DATA_LANES; j++) begin
			lanes.tdata[j] = tx_buf.tdata[j*`SERDES_CLK_RATIO + int'(phase)];
		end
		lanes.tstrb     = tx_buf.tstrb[phase];
		lanes.tkeep     = tx_buf.tkeep[phase];
		lanes.tid_tuser = id_nib[phase];
		lanes.fc        = fc_nib[phase];
	end

	assign serial_txd = lanes & {`SERDES_LANES{txen}};  // blank while off

	a_lanes_blank : assert property (
		@(posedge ioclk) disable iff (!axis_rst_n)
		!txen |-> serial_txd == '0
	);

endmodule

/* logic/serdes_link_ctrl.sv */
`timescale 1ns/1ps
`include "serdes_consts.svh"

module serdes_link_ctrl (
	input  logic                                ioclk,
	input  logic                                axis_rst_n,
	input  serdes_pkg::cfg_ctrl_t               ctrl,
	input  logic                                frame_valid,
	input  logic                                remote_tready,
	output logic [$clog2(`SERDES_CLK_RATIO)-1:0] phase,
	output logic                                txen,
	output logic                                rxen,
	output logic                                is_as_tready
);

	localparam int PH_W = $clog2(`SERDES_CLK_RATIO);
	localparam logic [PH_W-1:0] LAST_PH = PH_W'(`SERDES_LAST_PHASE);

	logic [PH_W-1:0]         phase_q;
	serdes_pkg::link_state_e tx_state_q;
	serdes_pkg::link_state_e tx_state_d;
	logic                    rxen_q;
	logic                    rx_seen_q;
	logic                    rdy_q;

	////////////////////
	// frame phase, shared by both directions
	always_ff @(posedge ioclk or negedge axis_rst_n) begin
		if (!axis_rst_n) begin
			phase_q <= '0;
		end else begin
			phase_q <= phase_q + 1'b1;  // wraps at ratio
		end
	end

	assign phase = phase_q;

	////////////////////
	// transmit start-up

	// far side talking to us also turns our transmitter on,
	// otherwise it would never see a ready from this end
	always_comb begin
		tx_state_d = tx_state_q;
		case (tx_state_q)
			serdes_pkg::LINK_OFF: begin
				if (phase_q == LAST_PH && (ctrl.txen_ctl || rx_seen_q)) begin
					tx_state_d = serdes_pkg::LINK_ON;
				end
			end
			default: tx_state_d = serdes_pkg::LINK_ON;  // stays on until reset
		endcase
	end

	always_ff @(posedge ioclk or negedge axis_rst_n) begin
		if (!axis_rst_n) begin
			tx_state_q <= serdes_pkg::LINK_OFF;
			rxen_q     <= 1'b0;
			rx_seen_q  <= 1'b0;
		end else begin
			tx_state_q <= tx_state_d;
			rxen_q     <= rxen_q | ctrl.rxen_ctl;      // sticky
			rx_seen_q  <= rx_seen_q | frame_valid;
		end
	end

	assign txen = (tx_state_q == serdes_pkg::LINK_ON);
	assign rxen = rxen_q;

	// ready toward the local stream source
	always_ff @(posedge ioclk or negedge axis_rst_n) begin
		if (!axis_rst_n) begin
			rdy_q <= 1'b0;
		end else if (!txen) begin
			rdy_q <= 1'b0;
		end else if (!rx_seen_q) begin
			rdy_q <= 1'b1;  // nothing heard yet, assume far side can take data
		end else begin
			rdy_q <= remote_tready;
		end
	end

	assign is_as_tready = rdy_q;

	// transmit switches on only across a frame boundary
	a_txen_on_boundary : assert property (
		@(posedge ioclk) disable iff (!axis_rst_n)
		$rose(txen) |-> $past(phase_q) == LAST_PH
	);

endmodule

/* logic/serdes_cfg_regs.sv */
`timescale 1ns/1ps
`include "serdes_consts.svh"

module serdes_cfg_regs (
	input  logic                       ioclk,
	input  logic                       axis_rst_n,
	input  logic                       cc_is_enable,
	input  serdes_pkg::cfg_write_t     cfg_wr,
	output logic                       awready,
	output logic                       wready,
	output logic                       arready,
	output logic                       rvalid,
	output logic [`SERDES_DATA_W-1:0]  rdata,
	output serdes_pkg::cfg_ctrl_t      ctrl
);

	logic                  wr_accept;
	logic                  ctrl_hit;
	serdes_pkg::cfg_ctrl_t ctrl_q;

	////////////////////
	// write side

	// address and data are taken in the same cycle
	assign wr_accept = cfg_wr.awvalid & cfg_wr.wvalid & cc_is_enable;
	assign awready   = wr_accept;
	assign wready    = wr_accept;

	// only byte lane 0 of the control dword holds anything
	assign ctrl_hit = (cfg_wr.awaddr[11:2] == serdes_pkg::REG_CTRL) && cfg_wr.wstrb[0];

	always_ff @(posedge ioclk or negedge axis_rst_n) begin
		if (!axis_rst_n) begin
			ctrl_q <= '0;
		end else if (wr_accept && ctrl_hit) begin
			ctrl_q.rxen_ctl <= cfg_wr.wdata[0];
			ctrl_q.txen_ctl <= cfg_wr.wdata[1];
		end
	end

	assign ctrl = ctrl_q;

	////////////////////
	// read side

	// always ready, address ignored
	assign arready = 1'b1;
	assign rvalid  = 1'b1;
	assign rdata   = {{(`SERDES_DATA_W - $bits(ctrl_q)){1'b0}}, ctrl_q};

	// both write channels are accepted together or not at all
	a_wr_accept_paired : assert property (
		@(posedge ioclk) disable iff (!axis_rst_n)
		awready == wready
	);

endmodule

/* logic/serdes_pkg.sv */
`include "serdes_consts.svh"

package serdes_pkg;

	////////////////////
	// stream beat, 47 bits
	typedef struct packed {
		logic [`SERDES_DATA_W-1:0]   tdata;
		logic [`SERDES_DATA_W/8-1:0] tstrb;
		logic [`SERDES_DATA_W/8-1:0] tkeep;
		logic [1:0]                  tid;
		logic [1:0]                  tuser;
		logic                        tlast;
		logic                        tvalid;
		logic                        tready;
	} axis_beat_t;

	// one ioclk cycle on the wire
	typedef struct packed {
		logic                          fc;         // {0, tlast, tvalid, tready}
		logic                          tid_tuser;  // {tid, tuser}
		logic                          tkeep;
		logic                          tstrb;
		logic [`SERDES_DATA_LANES-1:0] tdata;      // lane j carries tdata[4j+3:4j]
	} serial_lanes_t;

	////////////////////
	// AXI-Lite write request
	typedef struct packed {
		logic                          awvalid;
		logic [`SERDES_CFG_ADDR_W-1:0] awaddr;
		logic                          wvalid;
		logic [`SERDES_DATA_W-1:0]     wdata;
		logic [`SERDES_DATA_W/8-1:0]   wstrb;
	} cfg_write_t;

	typedef struct packed {
		logic txen_ctl;  // bit 1
		logic rxen_ctl;  // bit 0
	} cfg_ctrl_t;

	typedef enum logic {
		LINK_OFF = 1'b0,
		LINK_ON  = 1'b1
	} link_state_e;

	// dword offsets, everything else is reserved
	typedef enum logic [9:0] {
		REG_CTRL = 10'h000
	} cfg_reg_e;

endpackage

/* include/serdes_consts.svh */
`ifndef SERDES_CONSTS_SVH
`define SERDES_CONSTS_SVH

////////////////////
// stream side
`define SERDES_DATA_W       32

// ioclk cycles per frame, one stream beat per frame
`define SERDES_CLK_RATIO    4

////////////////////
// serial side
`define SERDES_DATA_LANES   (`SERDES_DATA_W / `SERDES_CLK_RATIO)
`define SERDES_LANES        12  // data lanes + tstrb, tkeep, tid/tuser, fc

// configuration port
`define SERDES_CFG_ADDR_W   15

`define SERDES_LAST_PHASE   (`SERDES_CLK_RATIO - 1)  // phase that closes a frame

`endif
